//--- verilog.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_roi_gen.sv
hdl/conv_kernel_ctrl.sv
hdl/conv_col_mac.sv
hdl/conv_datapath.sv
hdl/conv3x3_unit.sv
testbench/conv3x3_tb.sv

//--- testbench/conv3x3_tb.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv3x3_tb
	import conv_pkg::*;
();

	localparam int TIMEOUT = 2000; // cycles per wait loop
	localparam int MAX_R   = 4;
	localparam int MAX_W   = 12;

	logic      clk;
	logic      rst_n;
	conv_cfg_t cfg;
	ft_col_t   col;
	logic      col_valid;
	logic      col_ready;
	win9_u     kernel;
	logic      kernel_valid;
	logic      kernel_ready;
	logic      kernel_flush;
	res_t      res;
	logic      res_valid;

	integer    seed;
	int        errors;   // wrong values
	int        failures; // timeouts, stray results
	int        res_cnt;  // results seen since reset
	bit        gate_en;  // random gaps in col_valid
	string     test_name;
	res_t      exp_q [$]; // expected results in order
	res_t      exp_r;
	win9_u     kern_q [$]; // kernels still to send
	win9_u     junk;
	logic [2:0][`CONV_DW-1:0] map_px [MAX_R][MAX_W];
	win9_u     map_k [MAX_R]; // one kernel per row

	initial clk = 1'b0;
	always #4 clk = ~clk;

	conv3x3_unit DUT (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.col(col),
		.col_valid(col_valid),
		.col_ready(col_ready),
		.kernel(kernel),
		.kernel_valid(kernel_valid),
		.kernel_ready(kernel_ready),
		.kernel_flush(kernel_flush),
		.res(res),
		.res_valid(res_valid)
	);

	// candidate i survives the stride when its phase matches
	function automatic bit keep_cand(input int i, input int step, input bit drop);
		return (i % step) == (drop ? step - 1 : 0);
	endfunction

	// nine shifted products, summed with 24-bit wrap, then sign extended
	function automatic logic [`CONV_OUT_W-1:0] ref_conv(input win9_u w, input win9_u k);
		logic signed [2*`CONV_DW-1:0] p;
		logic [`CONV_RES_W-1:0]       acc;
		acc = '0;
		for (int i = 0; i < 9; i++)
		begin
			p   = $signed(w.taps[i]) * $signed(k.taps[i]);
			p   = p >>> (`CONV_FRAC - `CONV_EXT_FRAC); // keep 4 fraction bits
			acc = acc + p[`CONV_RES_W-1:0];
		end
		return {{(`CONV_OUT_W - `CONV_RES_W){acc[`CONV_RES_W-1]}}, acc};
	endfunction

	function automatic logic [`CONV_DW-1:0] rand_word(input bit extreme);
		logic [31:0] r;
		r = $random(seed);
		if (extreme)
			return r[0] ? 16'h7fff : 16'h8000; // full scale either sign
		return r[`CONV_DW-1:0];
	endfunction

	task automatic finish_run();
		$display("errors: %0d wrong values, %0d other failures", errors, failures);
		if (errors == 0 && failures == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		failures++;
		$display("timed out waiting for %s in %s", what, test_name);
		finish_run();
	endtask

	// kernel stream, front of kern_q held until taken
	always @(posedge clk)
	begin
		if (kernel_valid && kernel_ready)
			void'(kern_q.pop_front());
		if (!kernel_valid || kernel_ready)
		begin
			if (kern_q.size() > 0)
			begin
				kernel       <= kern_q[0];
				kernel_valid <= 1'b1;
			end
			else
				kernel_valid <= 1'b0;
		end
	end

	// compare every result against the queue
	always @(posedge clk)
	begin
		if (rst_n && res_valid)
		begin
			res_cnt++;
			if (exp_q.size() == 0)
			begin
				failures++;
				$display("result %h arrived with nothing expected in %s", res.data, test_name);
			end
			else
			begin
				exp_r = exp_q.pop_front();
				if (res.data !== exp_r.data)
				begin
					errors++;
					$display("Error %s: data expected %h, actual %h",
						test_name, exp_r.data, res.data);
				end
				if (res.last !== exp_r.last)
				begin
					errors++;
					$display("Error %s: last expected %b, actual %b",
						test_name, exp_r.last, res.last);
				end
			end
		end
	end

	task automatic send_col(input ft_col_t c);
		int t;
		if (gate_en)
			while (($random(seed) & 3) == 0) // idle gap before this column
			begin
				col_valid <= 1'b0;
				@(posedge clk);
			end
		col       <= c;
		col_valid <= 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			t++;
		end
		while (!col_ready && t < TIMEOUT);
		if (!col_ready)
			report_timeout("column handshake");
	endtask

	task automatic stream_rows(input int w, input int rows);
		ft_col_t c;
		for (int r = 0; r < rows; r++)
			for (int x = 0; x < w; x++)
			begin
				c.pix  = map_px[r][x];
				c.last = (x == w - 1);
				c.user = (r == rows - 1); // last row of the map
				send_col(c);
			end
		col_valid <= 1'b0;
	endtask

	// withheld kernels go out once the stall has been seen
	task automatic release_kernels(input int base, input int n_seen, input int from_row,
		input int rows);
		repeat (60) @(posedge clk); // observation window for the stall
		if (res_cnt - base != n_seen)
		begin
			errors++;
			$display("Error %s: results before kernel expected %0d, actual %0d",
				test_name, n_seen, res_cnt - base);
		end
		for (int r = from_row; r < rows; r++)
			kern_q.push_back(map_k[r]);
	endtask

	// no result pending and the kernel stream drained
	task automatic wait_idle();
		int t;
		t = 0;
		while ((exp_q.size() != 0 || kern_q.size() != 0 || kernel_valid) && t < TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0 || kern_q.size() != 0 || kernel_valid)
			report_timeout("results and kernels to drain");
	endtask

	task automatic run_map(input string name, input bit k3, input bit pl, input bit pr,
		input int step, input bit drop, input int w, input int rows, input int hold_row,
		input bit extreme);
		int    lp;
		int    rp;
		int    n_cand;
		int    n_keep;
		int    kept;
		int    base;
		logic [2:0][`CONV_DW-1:0] prow [MAX_W + 2];
		win9_u win;
		res_t  e;
		wait_idle();
		test_name = name;
		lp = (!k3 || pl) ? 1 : 0; // 1x1 forces both pads
		rp = (!k3 || pr) ? 1 : 0;
		n_cand = w - 2 + lp + rp;
		n_keep = 0;
		for (int i = 0; i < n_cand; i++)
			if (keep_cand(i, step, drop))
				n_keep++;
		cfg <= '{kernel_3x3: k3, pad_left: pl, pad_right: pr,
			out_w_m1: 16'(n_keep - 1), h_step_m1: 3'(step - 1), drop_first: drop};
		kernel_flush <= 1'b1; // back to the post-reset kernel state
		@(posedge clk);
		kernel_flush <= 1'b0;
		for (int r = 0; r < rows; r++)
		begin
			for (int t = 0; t < 9; t++)
				map_k[r].taps[t] = (k3 || t == 4) ? rand_word(extreme) : '0; // 1x1 uses center
			for (int x = 0; x < w; x++)
				for (int y = 0; y < 3; y++)
					map_px[r][x][y] = rand_word(extreme);
			for (int j = 0; j < w + lp + rp; j++)
				prow[j] = (j < lp || j >= w + lp) ? '0 : map_px[r][j - lp];
			kept = 0;
			for (int i = 0; i < n_cand; i++)
				if (keep_cand(i, step, drop))
				begin
					for (int x = 0; x < 3; x++)
						for (int y = 0; y < 3; y++)
							win.taps[3 * x + y] = prow[i + x][y];
					kept++;
					e.data = ref_conv(win, map_k[r]);
					e.last = (kept == n_keep);
					exp_q.push_back(e);
				end
		end
		for (int r = 0; r < hold_row; r++)
			kern_q.push_back(map_k[r]);
		base = res_cnt;
		fork
			stream_rows(w, rows);
			if (hold_row < rows)
				release_kernels(base, hold_row * n_keep - 1, hold_row, rows);
		join
		wait_idle();
	endtask

	initial
	begin
		seed         = 32'hf6ce;
		errors       = 0;
		failures     = 0;
		res_cnt      = 0;
		gate_en      = 1'b1;
		test_name    = "reset";
		rst_n        = 1'b0;
		cfg          = '0;
		col          = '0;
		col_valid    = 1'b0;
		kernel       = '0;
		kernel_valid = 1'b0;
		kernel_flush = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// name, 3x3, pad l, pad r, stride, drop, width, rows, first held row, extreme
		run_map("stride1", 1, 0, 0, 1, 0, 8, 3, 3, 0);
		run_map("pad_both", 1, 1, 1, 1, 0, 7, 2, 2, 0);
		run_map("one_by_one", 0, 0, 0, 1, 0, 6, 2, 2, 0);
		// widths chosen so the last candidate of a row is kept
		run_map("stride2_first", 1, 0, 0, 2, 0, 9, 2, 2, 0);
		run_map("stride2_drop", 1, 0, 0, 2, 1, 10, 2, 2, 0);
		run_map("stride3_first", 1, 0, 0, 3, 0, 9, 2, 2, 0);
		run_map("stride3_drop", 1, 0, 0, 3, 1, 11, 2, 2, 0);
		gate_en = 1'b0; // back to back columns, pipeline full across row ends
		run_map("kernel_switch", 1, 0, 0, 1, 0, 5, 4, 4, 0);
		run_map("starve", 1, 0, 0, 1, 0, 6, 2, 1, 0);
		// stale kernel parked in the shadow, flushed by the next map
		for (int t = 0; t < 9; t++)
			junk.taps[t] = rand_word(1'b0);
		kern_q.push_back(junk);
		run_map("after_flush", 1, 0, 0, 1, 0, 6, 1, 1, 0);
		gate_en = 1'b1;
		run_map("wrap", 1, 0, 0, 1, 0, 6, 2, 2, 1);
		wait_idle();
		repeat (10) @(posedge clk); // stray late results
		finish_run();
	end

endmodule

//--- hdl/conv3x3_unit.sv
`timescale 1ns/1ps

module conv3x3_unit
	import conv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  conv_cfg_t cfg,
	input  ft_col_t   col,
	input  logic      col_valid,
	output logic      col_ready,
	input  win9_u     kernel,
	input  logic      kernel_valid,
	output logic      kernel_ready,
	input  logic      kernel_flush,
	output res_t      res,
	output logic      res_valid
);

	roi_t       roi;
	logic       roi_valid;
	logic       roi_ready;
	logic       roi_fire;
	logic       kernel_allow;
	logic [2:0] mul_in_valid; // per column stage
	logic [2:0] mul_in_last;
	logic [2:0] shadow_load;
	logic [2:0] active_load;

	assign roi_fire = roi_valid & roi_ready;

	conv_roi_gen u_roi_gen (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.col(col),
		.col_valid(col_valid),
		.col_ready(col_ready),
		.roi(roi),
		.roi_valid(roi_valid),
		.roi_ready(roi_ready),
		.kernel_allow(kernel_allow)
	);

	conv_kernel_ctrl u_kernel_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.kernel_valid(kernel_valid),
		.kernel_ready(kernel_ready),
		.kernel_flush(kernel_flush),
		.roi_ready(roi_ready),
		.kernel_allow(kernel_allow),
		.mul_in_valid(mul_in_valid),
		.mul_in_last(mul_in_last),
		.shadow_load(shadow_load),
		.active_load(active_load)
	);

	conv_datapath u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.roi(roi),
		.roi_fire(roi_fire),
		.kernel(kernel),
		.shadow_load(shadow_load),
		.active_load(active_load),
		.mul_in_valid(mul_in_valid),
		.mul_in_last(mul_in_last),
		.res(res),
		.res_valid(res_valid)
	);

endmodule

//--- hdl/conv_datapath.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_datapath
	import conv_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  roi_t       roi,
	input  logic       roi_fire,
	input  win9_u      kernel,
	input  logic [2:0] shadow_load,
	input  logic [2:0] active_load,
	output logic [2:0] mul_in_valid,
	output logic [2:0] mul_in_last,
	output res_t       res,
	output logic       res_valid
);

	logic [2:0][`CONV_DW-1:0] pix_c1;    // roi column 1, one cycle late
	logic [2:0][`CONV_DW-1:0] pix_c2_d1;
	logic [2:0][`CONV_DW-1:0] pix_c2;    // roi column 2, two cycles late
	logic [2:0][`CONV_DW-1:0] col_pix [3];
	logic [`CONV_RES_W-1:0]   col_sum [3];
	logic [1:0]               stg_vld;   // column 1 and 2 input valid
	logic [1:0]               stg_last;
	logic [2:0]               out_vld;   // cycles 3..5 after the handshake
	logic [2:0]               out_last;
	logic [`CONV_RES_W-1:0]   sum0_d1;
	logic [`CONV_RES_W-1:0]   sum0_d2;   // column 0 sum aligned to column 2
	logic [`CONV_RES_W-1:0]   sum1_d1;   // column 1 sum aligned to column 2
	logic [`CONV_RES_W-1:0]   res_sum;

	assign col_pix[0] = roi.win.cols[0];
	assign col_pix[1] = pix_c1;
	assign col_pix[2] = pix_c2;

	assign mul_in_valid = {stg_vld[1], stg_vld[0], roi_fire};
	assign mul_in_last  = {stg_last[1], stg_last[0], roi.last};

	genvar c;
	generate
		for (c = 0; c < 3; c++)
		begin : g_col
			conv_col_mac u_mac (
				.clk(clk),
				.rst_n(rst_n),
				.pix(col_pix[c]),
				.pix_valid(mul_in_valid[c]),
				.coef_in(kernel.cols[c]),
				.shadow_load(shadow_load[c]),
				.active_load(active_load[c]),
				.col_sum(col_sum[c])
			);
		end
	endgenerate

	// pixel stagger and sum alignment
	always_ff @(posedge clk)
	begin
		pix_c1    <= roi.win.cols[1];
		pix_c2_d1 <= roi.win.cols[2];
		pix_c2    <= pix_c2_d1;
		sum0_d1   <= col_sum[0];
		sum0_d2   <= sum0_d1;
		sum1_d1   <= col_sum[1];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stg_vld  <= '0;
			stg_last <= '0;
			out_vld  <= '0;
			out_last <= '0;
		end
		else
		begin
			stg_vld  <= {stg_vld[0], roi_fire};
			stg_last <= {stg_last[0], roi.last & roi_fire};
			out_vld  <= {out_vld[1:0], stg_vld[1]};
			out_last <= {out_last[1:0], stg_last[1]};
		end
	end

	// all three column sums line up in cycle 4
	always_ff @(posedge clk)
	begin
		if (out_vld[1])
			res_sum <= sum0_d2 + sum1_d1 + col_sum[2]; // wraps at CONV_RES_W
	end

	assign res_valid = out_vld[2];
	assign res = '{
		data: {{(`CONV_OUT_W - `CONV_RES_W){res_sum[`CONV_RES_W-1]}}, res_sum},
		last: out_last[2]
	};

endmodule

//--- hdl/conv_col_mac.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_col_mac (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [2:0][`CONV_DW-1:0] pix,
	input  logic                     pix_valid,
	input  logic [2:0][`CONV_DW-1:0] coef_in,
	input  logic                     shadow_load,
	input  logic                     active_load,
	output logic [`CONV_RES_W-1:0]   col_sum
);

	localparam int SHIFT = `CONV_FRAC - `CONV_EXT_FRAC; // keep EXT_FRAC fraction bits

	logic [2:0][`CONV_DW-1:0]       coef_sh;  // next row's taps
	logic [2:0][`CONV_DW-1:0]       coef_act; // taps in use
	logic signed [2*`CONV_DW-1:0]   prod [3];
	logic signed [2*`CONV_DW-1:0]   prod_q [3];
	logic                           prod_valid;
	logic [`CONV_RES_W-1:0]         sum_nxt;

	// active copy is taken from the old shadow when both load together
	always_ff @(posedge clk)
	begin
		if (shadow_load)
			coef_sh <= coef_in;
		if (active_load)
			coef_act <= coef_sh;
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
			for (int y = 0; y < 3; y++)
				prod[y] <= $signed(pix[y]) * $signed(coef_act[y]); // full width product
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			prod_valid <= 1'b0;
		else
			prod_valid <= pix_valid;
	end

	// quantize then add, wraps at CONV_RES_W
	always_comb
	begin
		for (int y = 0; y < 3; y++)
			prod_q[y] = prod[y] >>> SHIFT;
		sum_nxt = prod_q[0][`CONV_RES_W-1:0]
			+ prod_q[1][`CONV_RES_W-1:0]
			+ prod_q[2][`CONV_RES_W-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (prod_valid)
			col_sum <= sum_nxt;
	end

endmodule

//--- hdl/conv_kernel_ctrl.sv
`timescale 1ns/1ps

module conv_kernel_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       kernel_valid,
	output logic       kernel_ready,
	input  logic       kernel_flush,
	output logic       roi_ready,
	output logic       kernel_allow,
	input  logic [2:0] mul_in_valid,
	input  logic [2:0] mul_in_last,
	output logic [2:0] shadow_load,
	output logic [2:0] active_load
);

	logic       init_pend;   // waiting for the first kernel
	logic       init_now;    // first kernel moves shadow to active
	logic       shadow_full; // next kernel buffered
	logic       switching;   // column 0 switched, column 2 not yet
	logic [2:0] row_done;    // column takes the row's last roi
	logic       kernel_fire;

	assign row_done    = mul_in_valid & mul_in_last;
	assign kernel_fire = kernel_valid & kernel_ready;

	// no rois until the active taps hold a kernel
	assign roi_ready = ~(init_pend | init_now);

	// shadow frees up as column 2, the last reader, switches
	assign kernel_ready = ~shadow_full | init_pend | row_done[2];

	assign kernel_allow = shadow_full & ~switching;

	assign shadow_load = {3{kernel_fire}};
	assign active_load = {3{init_now}} | row_done; // staggered per column on row end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			init_pend <= 1'b1;
		else if (kernel_flush)
			init_pend <= 1'b1;
		else if (init_pend)
			init_pend <= ~kernel_valid;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			init_now <= 1'b0;
		else
			init_now <= init_pend & kernel_valid & ~kernel_flush;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			shadow_full <= 1'b0;
		else if (kernel_flush | init_now)
			shadow_full <= 1'b0; // initial kernel already copied out
		else if (kernel_ready)
			shadow_full <= kernel_valid;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			switching <= 1'b0;
		else if (kernel_flush)
			switching <= 1'b0;
		else if (row_done[0] | row_done[2])
			switching <= row_done[0];
	end

	// a second row end inside the stagger would leave column 2 on a stale kernel
	a_switch_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(row_done[0] && row_done[2]))
		else $error("columns 0 and 2 switch kernels in the same cycle");

	a_shadow_safe: assert property (@(posedge clk) disable iff (!rst_n)
		(kernel_fire && shadow_full) |-> row_done[2])
		else $error("kernel written over a shadow that is still pending");

endmodule

//--- hdl/conv_roi_gen.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_roi_gen
	import conv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  conv_cfg_t cfg,
	input  ft_col_t   col,
	input  logic      col_valid,
	output logic      col_ready,
	output roi_t      roi,
	output logic      roi_valid,
	input  logic      roi_ready,
	input  logic      kernel_allow
);

	localparam int CID_W = $clog2(`CONV_MAX_W);

	logic [2:0][`CONV_DW-1:0] col_now; // x3 of the window
	logic [2:0][`CONV_DW-1:0] col_b0;  // x2, previous column
	logic [2:0][`CONV_DW-1:0] col_b1;  // x1, zero right after the first column
	logic [3:0]               pos;     // first, second, steady, right pad
	logic                     need_lpad;
	logic                     need_rpad;
	logic [7:0]               step_cnt; // one-hot candidate phase within a stride
	logic [7:0]               step_mask;
	logic                     step_last;
	logic                     step_wrap;
	logic                     skip;       // current candidate is not kept
	logic                     row_end_ok; // row-last column may be taken
	logic                     col_fire;
	logic                     rpad_go;    // leave the right pad slot
	logic                     cand_go;    // a candidate window is consumed
	logic                     pos_go;
	logic [CID_W-1:0]         cid;        // output column index

	// 1x1 runs as a padded 3x3
	assign need_lpad = ~cfg.kernel_3x3 | cfg.pad_left;
	assign need_rpad = ~cfg.kernel_3x3 | cfg.pad_right;

	assign step_mask = 8'd1 << cfg.h_step_m1;
	assign step_last = |(step_cnt & step_mask);
	// last candidate of a row restarts the phase
	assign step_wrap = pos[3] | step_last | (pos[2] & col.last & ~need_rpad);
	assign skip      = cfg.drop_first ? ~step_last : ~step_cnt[0];

	// next row's kernel must be buffered before this row closes, unless the map is done
	assign row_end_ok = ~col.last | col.user | kernel_allow;

	assign col_ready = pos[0]
		| (pos[1] & (~need_lpad | skip | roi_ready))
		| (pos[2] & row_end_ok & (skip | roi_ready));
	assign col_fire = col_valid & col_ready;

	assign roi_valid = ~skip & ((pos[1] & col_valid & need_lpad)
		| (pos[2] & col_valid & row_end_ok)
		| (pos[3] & need_rpad));

	// right pad slot needs no input column
	assign rpad_go = pos[3] & (~need_rpad | skip | roi_ready);
	assign cand_go = (col_fire & (pos[2] | (pos[1] & need_lpad))) | rpad_go;
	assign pos_go  = (col_fire & (pos[0] | pos[1] | (pos[2] & col.last))) | rpad_go;

	assign col_now = pos[3] ? '0 : col.pix; // zero column on the right

	always_comb
	begin
		for (int y = 0; y < 3; y++)
		begin
			roi.win.taps[y]     = col_b1[y];
			roi.win.taps[3 + y] = col_b0[y];
			roi.win.taps[6 + y] = col_now[y];
		end
		roi.last = cid == cfg.out_w_m1[CID_W-1:0];
	end

	// column history
	always_ff @(posedge clk)
	begin
		if (col_fire)
		begin
			col_b0 <= col_now;
			col_b1 <= pos[0] ? '0 : col_b0; // left pad column
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pos <= 4'b0001;
		else if (pos_go)
			pos <= {pos[2:0], pos[3]}; // right pad wraps back to first
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			step_cnt <= 8'd1;
		else if (cand_go)
			step_cnt <= step_wrap ? 8'd1 : {step_cnt[6:0], step_cnt[7]};
	end

	// counts kept windows only
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cid <= '0;
		else if (roi_valid & roi_ready)
			cid <= roi.last ? '0 : cid + 1'b1;
	end

	a_pos_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(pos))
		else $error("roi generator column position is not one-hot");

endmodule

//--- hdl/conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

	// one feature map column, three vertically adjacent pixels
	typedef struct packed {
		logic [2:0][`CONV_DW-1:0] pix; // pix[0] is row 0
		logic                     last; // end of the input row
		logic                     user; // last group of the map
	} ft_col_t;

	// 3x3 word, column major
	// taps[x*3+y] and cols[x][y] name the same word, x1y1 first, x3y3 last
	typedef union packed {
		logic [8:0][`CONV_DW-1:0]      taps;
		logic [2:0][2:0][`CONV_DW-1:0] cols; // cols[x] is one kernel column
	} win9_u;

	typedef struct packed {
		win9_u win;
		logic  last; // last roi of the row
	} roi_t;

	// held stable while a map streams
	typedef struct packed {
		logic        kernel_3x3; // low selects 1x1, both pads forced on
		logic        pad_left;
		logic        pad_right;
		logic [15:0] out_w_m1;   // output width - 1
		logic [2:0]  h_step_m1;  // horizontal stride - 1
		logic        drop_first; // keep phase stride-1 instead of 0
	} conv_cfg_t;

	typedef struct packed {
		logic [`CONV_OUT_W-1:0] data; // sign extended from CONV_RES_W
		logic                   last; // end of output row
	} res_t;

endpackage

//--- hdl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// pixel and coefficient word, signed
`define CONV_DW       16
// fraction bits of a kernel coefficient
`define CONV_FRAC     10

// guard bits kept in the column and final sums
`define CONV_EXT_INT  4
`define CONV_EXT_FRAC 4

// valid part of a result, binary point sits CONV_EXT_FRAC above bit 0
`define CONV_RES_W    (`CONV_EXT_INT + `CONV_DW + `CONV_EXT_FRAC)

// result word as it leaves the unit
`define CONV_OUT_W    32

// widest feature map, sets the output column index width
`define CONV_MAX_W    512

`endif
